// File: Bender.yml
package:
  name: l2c

sources:
  - hw/l2c_pkg.sv
  - hw/l2c_l1_port.sv
  - hw/l2c_arbiter.sv
  - hw/l2c_store.sv
  - hw/l2c_miss.sv
  - hw/l2c_top.sv
  - target: test
    files:
      - verification/l2c_clkgen.sv
      - verification/l2c_checker.sv
      - verification/l2c_tb.sv

// File: hw/l2c_arbiter.sv
// ==============================
// L2 cache store arbiter
// Round-robin between the two port engines, no grant in fill cycles
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_arbiter (
   input  logic                          clk_mc,
   input  logic                          i_reset,
   input  logic [l2c_pkg::N_PORTS-1:0]   i_req,
   input  logic                          i_fill_busy,
   output logic [l2c_pkg::N_PORTS-1:0]   o_grant,
   output logic [l2c_pkg::PORT_W-1:0]    o_sel
);
   import l2c_pkg::*;

   // Port that wins a tie next
   logic [PORT_W-1:0] ptr_q;
   logic [PORT_W-1:0] other;

   assign other = (ptr_q == PORT_IL1) ? PORT_DL1 : PORT_IL1;

   always_comb begin
      o_grant = '0;
      o_sel   = ptr_q;
      if (!i_fill_busy) begin
         if (i_req[ptr_q]) begin
            o_grant[ptr_q] = 1'b1;
         end else if (i_req[other]) begin
            o_grant[other] = 1'b1;
            o_sel          = other;
         end
      end
   end

   // Winner drops to lowest priority
   always_ff @(posedge clk_mc) begin
      if (i_reset) begin
         ptr_q <= PORT_IL1;
      end else if (|o_grant) begin
         ptr_q <= (o_sel == PORT_IL1) ? PORT_DL1 : PORT_IL1;
      end
   end

endmodule

`default_nettype wire

// File: hw/l2c_l1_port.sv
// ==============================
// L2 cache L1 port engine
// Takes one L1 request, looks it up in the store,
// goes to the miss channel when needed, answers the L1
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_l1_port #(
   parameter bit CAN_WRITE = 1'b1
) (
   input  logic                         clk_mc,
   input  logic                         i_reset,
   // L1 side
   input  logic [l2c_pkg::ADR_W-1:0]    i_l1_adr,
   input  logic                         i_l1_wen,
   input  logic [l2c_pkg::BE_W-1:0]     i_l1_ben,
   input  logic [l2c_pkg::DATA_W-1:0]   i_l1_wdata,
   input  logic                         i_l1_valid,
   output logic                         o_l1_rdata_valid,
   output logic [l2c_pkg::DATA_W-1:0]   o_l1_rdata,
   output logic                         o_l1_stall,
   // Store side
   output logic                         o_lookup_req,
   output logic [l2c_pkg::ADR_W-1:0]    o_lookup_adr,
   output logic                         o_lookup_wen,
   output logic [l2c_pkg::BE_W-1:0]     o_lookup_ben,
   output logic [l2c_pkg::DATA_W-1:0]   o_lookup_wdata,
   input  logic                         i_grant,
   input  logic                         i_lookup_hit,
   input  logic [l2c_pkg::DATA_W-1:0]   i_lookup_rdata,
   // Miss side
   output logic                         o_miss_req,
   input  logic                         i_miss_done,
   input  logic [l2c_pkg::DATA_W-1:0]   i_fill_data
);
   import l2c_pkg::*;

   localparam logic [1:0] ST_IDLE      = 2'd0;
   localparam logic [1:0] ST_LOOKUP    = 2'd1;
   localparam logic [1:0] ST_WAIT_MISS = 2'd2;
   localparam logic [1:0] ST_RESPOND   = 2'd3;

   logic [1:0]        state_q;
   logic              granted_q;
   logic [ADR_W-1:0]  adr_q;
   logic              wen_q;
   logic [BE_W-1:0]   ben_q;
   logic [DATA_W-1:0] wdata_q;
   logic [DATA_W-1:0] rdata_q;
   logic              accept;
   logic              result_cyc;

   assign o_l1_stall = (state_q != ST_IDLE);
   assign accept     = i_l1_valid && !o_l1_stall;
   // Store answers one cycle after the grant
   assign result_cyc = (state_q == ST_LOOKUP) && granted_q;

   // ==============================
   // Engine FSM
   // ==============================
   always_ff @(posedge clk_mc) begin
      if (i_reset) begin
         state_q   <= ST_IDLE;
         granted_q <= 1'b0;
         wen_q     <= 1'b0;
      end else begin
         case (state_q)
            ST_IDLE: begin
               if (accept) begin
                  state_q   <= ST_LOOKUP;
                  granted_q <= 1'b0;
                  wen_q     <= CAN_WRITE && i_l1_wen;
               end
            end
            ST_LOOKUP: begin
               if (granted_q) begin
                  // Read hits finish here, everything else goes out
                  if (i_lookup_hit && !wen_q) begin
                     state_q <= ST_RESPOND;
                  end else begin
                     state_q <= ST_WAIT_MISS;
                  end
               end else if (i_grant) begin
                  granted_q <= 1'b1;
               end
            end
            ST_WAIT_MISS: begin
               if (i_miss_done) begin
                  state_q <= ST_RESPOND;
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Request capture and read data
   always_ff @(posedge clk_mc) begin
      if (accept) begin
         adr_q   <= i_l1_adr;
         ben_q   <= CAN_WRITE ? i_l1_ben : '0;
         wdata_q <= CAN_WRITE ? i_l1_wdata : '0;
      end
      if (result_cyc) begin
         rdata_q <= i_lookup_rdata;
      end else if ((state_q == ST_WAIT_MISS) && i_miss_done && !wen_q) begin
         rdata_q <= i_fill_data;
      end
   end

   assign o_lookup_req     = (state_q == ST_LOOKUP) && !granted_q;
   assign o_lookup_adr     = adr_q;
   assign o_lookup_wen     = wen_q;
   assign o_lookup_ben     = ben_q;
   assign o_lookup_wdata   = wdata_q;

   assign o_miss_req       = (state_q == ST_WAIT_MISS);
   assign o_l1_rdata_valid = (state_q == ST_RESPOND);
   assign o_l1_rdata       = rdata_q;

endmodule

`default_nettype wire

// File: hw/l2c_miss.sv
// ==============================
// L2 cache miss channel
// One request at a time towards the network,
// read misses wait for their fill
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_miss (
   input  logic                          clk_mc,
   input  logic                          i_reset,
   // From the port engines
   input  logic [l2c_pkg::N_PORTS-1:0]   i_miss_req,
   input  logic [l2c_pkg::ADR_W-1:0]     i_il1_adr,
   input  logic [l2c_pkg::ADR_W-1:0]     i_dl1_adr,
   input  logic                          i_dl1_wen,
   input  logic [l2c_pkg::BE_W-1:0]      i_dl1_ben,
   input  logic [l2c_pkg::DATA_W-1:0]    i_dl1_wdata,
   // To the engines and the store
   output logic [l2c_pkg::N_PORTS-1:0]   o_miss_done,
   output logic [l2c_pkg::DATA_W-1:0]    o_fill_data,
   // Network miss channel
   output logic                          o_mni_miss_valid,
   output logic [l2c_pkg::ADR_W-1:0]     o_mni_miss_adr,
   output logic                          o_mni_miss_wen,
   output logic [l2c_pkg::BE_W-1:0]      o_mni_miss_ben,
   output logic [l2c_pkg::DATA_W-1:0]    o_mni_miss_wdata,
   input  logic                          i_mni_miss_stall,
   // Network fill
   input  logic                          i_mni_fill_valid,
   input  logic [l2c_pkg::ADR_W-1:0]     i_mni_fill_adr,
   input  logic [l2c_pkg::DATA_W-1:0]    i_mni_data
);
   import l2c_pkg::*;

   logic              valid_q;
   logic              wait_q;
   logic              wen_q;
   logic [PORT_W-1:0] owner_q;
   logic              issue;
   logic              pick_dl1;
   logic              xfer;
   logic              done;
   logic              fill_wr_match;

   assign issue    = !valid_q && !wait_q && (|i_miss_req);
   // Lowest requester number wins
   assign pick_dl1 = !i_miss_req[PORT_IL1];
   assign xfer     = valid_q && !i_mni_miss_stall;
   assign done     = (xfer && wen_q) || (wait_q && i_mni_fill_valid);

   // ==============================
   // Channel control
   // ==============================
   always_ff @(posedge clk_mc) begin
      if (i_reset) begin
         valid_q <= 1'b0;
         wait_q  <= 1'b0;
         wen_q   <= 1'b0;
         owner_q <= PORT_IL1;
      end else if (issue) begin
         valid_q <= 1'b1;
         wen_q   <= pick_dl1 && i_dl1_wen;
         owner_q <= pick_dl1 ? PORT_DL1 : PORT_IL1;
      end else if (xfer) begin
         valid_q <= 1'b0;
         wait_q  <= !wen_q;
      end else if (wait_q && i_mni_fill_valid) begin
         wait_q  <= 1'b0;
      end
   end

   // Payload held until the transfer
   always_ff @(posedge clk_mc) begin
      if (issue) begin
         o_mni_miss_adr   <= pick_dl1 ? i_dl1_adr : i_il1_adr;
         o_mni_miss_ben   <= pick_dl1 ? i_dl1_ben : '0;
         o_mni_miss_wdata <= i_dl1_wdata;
      end
   end

   always_comb begin
      o_miss_done = '0;
      if (done) begin
         o_miss_done[owner_q] = 1'b1;
      end
   end

   assign o_mni_miss_valid = valid_q;
   assign o_mni_miss_wen   = wen_q;

   // Install word carries the last data-L1 write to this word,
   // which may still be queued behind the read miss
   assign fill_wr_match = i_dl1_wen &&
                          (i_dl1_adr[ADR_W-1:OFS_W] == i_mni_fill_adr[ADR_W-1:OFS_W]);

   always_comb begin
      for (int b = 0; b < BE_W; b++) begin
         o_fill_data[8*b +: 8] = (fill_wr_match && i_dl1_ben[b]) ? i_dl1_wdata[8*b +: 8]
                                                                 : i_mni_data[8*b +: 8];
      end
   end

endmodule

`default_nettype wire

// File: hw/l2c_pkg.sv
// ==============================
// L2 cache shared definitions
// Widths, address fields, store geometry, requester numbers
// ==============================

`default_nettype none

package l2c_pkg;

   // ==============================
   // Bus widths
   // ==============================
   localparam int ADR_W   = 32;
   localparam int DATA_W  = 32;
   localparam int BE_W    = DATA_W / 8;

   // ==============================
   // Address split and geometry
   // ==============================
   // Byte offset inside the word
   localparam int OFS_W   = 2;
   localparam int INDEX_W = 6;
   localparam int TAG_W   = ADR_W - INDEX_W - OFS_W;
   localparam int LINES   = 1 << INDEX_W;

   // Requesters sharing the store and the miss channel
   localparam int N_PORTS = 2;
   localparam int PORT_W  = $clog2(N_PORTS);
   localparam logic [PORT_W-1:0] PORT_IL1 = PORT_W'(0);
   localparam logic [PORT_W-1:0] PORT_DL1 = PORT_W'(1);

endpackage

`default_nettype wire

// File: hw/l2c_store.sv
// ==============================
// L2 cache tag and data store
// Direct mapped, one word per line
// Lookup with write merge, fill install
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_store (
   input  logic                         clk_mc,
   input  logic                         i_reset,
   // Lookup from the granted engine
   input  logic                         i_lookup_valid,
   input  logic [l2c_pkg::ADR_W-1:0]    i_lookup_adr,
   input  logic                         i_lookup_wen,
   input  logic [l2c_pkg::BE_W-1:0]     i_lookup_ben,
   input  logic [l2c_pkg::DATA_W-1:0]   i_lookup_wdata,
   output logic                         o_lookup_hit,
   output logic [l2c_pkg::DATA_W-1:0]   o_lookup_rdata,
   // Fill install
   input  logic                         i_fill_valid,
   input  logic [l2c_pkg::ADR_W-1:0]    i_fill_adr,
   input  logic [l2c_pkg::DATA_W-1:0]   i_fill_data
);
   import l2c_pkg::*;

   logic [LINES-1:0]   valid_q;
   logic [TAG_W-1:0]   tag_mem  [LINES];
   logic [DATA_W-1:0]  data_mem [LINES];

   logic [INDEX_W-1:0] lk_index;
   logic [TAG_W-1:0]   lk_tag;
   logic               lk_hit;
   logic [INDEX_W-1:0] fl_index;
   logic [TAG_W-1:0]   fl_tag;
   logic [DATA_W-1:0]  merged;

   // ==============================
   // Address split
   // ==============================
   assign lk_index = i_lookup_adr[OFS_W +: INDEX_W];
   assign lk_tag   = i_lookup_adr[ADR_W-1 -: TAG_W];
   assign fl_index = i_fill_adr[OFS_W +: INDEX_W];
   assign fl_tag   = i_fill_adr[ADR_W-1 -: TAG_W];

   assign lk_hit = valid_q[lk_index] && (tag_mem[lk_index] == lk_tag);

   // Enabled bytes from the write, the rest from the line
   always_comb begin
      for (int b = 0; b < BE_W; b++) begin
         merged[8*b +: 8] = i_lookup_ben[b] ? i_lookup_wdata[8*b +: 8]
                                            : data_mem[lk_index][8*b +: 8];
      end
   end

   // Valid bits and lookup result
   always_ff @(posedge clk_mc) begin
      if (i_reset) begin
         valid_q      <= '0;
         o_lookup_hit <= 1'b0;
      end else begin
         o_lookup_hit <= i_lookup_valid && lk_hit;
         if (i_fill_valid) begin
            valid_q[fl_index] <= 1'b1;
         end
      end
   end

   // Arrays, the arbiter keeps lookups out of fill cycles
   always_ff @(posedge clk_mc) begin
      o_lookup_rdata <= data_mem[lk_index];
      if (i_fill_valid) begin
         tag_mem[fl_index]  <= fl_tag;
         data_mem[fl_index] <= i_fill_data;
      end else if (i_lookup_valid && i_lookup_wen && lk_hit) begin
         data_mem[lk_index] <= merged;
      end
   end

endmodule

`default_nettype wire

// File: hw/l2c_top.sv
// ==============================
// L2 cache top level
// Two L1 port engines, store arbiter, store and miss channel
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_top (
   input  logic                         clk_mc,
   input  logic                         i_reset,
   // Instruction L1
   input  logic [l2c_pkg::ADR_W-1:0]    i_il1_adr,
   input  logic                         i_il1_valid,
   output logic                         o_il1_rdata_valid,
   output logic [l2c_pkg::DATA_W-1:0]   o_il1_rdata,
   output logic                         o_il1_stall,
   // Data L1
   input  logic [l2c_pkg::ADR_W-1:0]    i_dl1_adr,
   input  logic                         i_dl1_wen,
   input  logic [l2c_pkg::BE_W-1:0]     i_dl1_ben,
   input  logic [l2c_pkg::DATA_W-1:0]   i_dl1_wdata,
   input  logic                         i_dl1_valid,
   output logic                         o_dl1_rdata_valid,
   output logic [l2c_pkg::DATA_W-1:0]   o_dl1_rdata,
   output logic                         o_dl1_stall,
   // Network miss channel
   output logic                         o_mni_miss_valid,
   output logic [l2c_pkg::ADR_W-1:0]    o_mni_miss_adr,
   output logic                         o_mni_miss_wen,
   output logic [l2c_pkg::BE_W-1:0]     o_mni_miss_ben,
   output logic [l2c_pkg::DATA_W-1:0]   o_mni_miss_wdata,
   input  logic                         i_mni_miss_stall,
   // Network fill
   input  logic                         i_mni_fill_valid,
   input  logic [l2c_pkg::ADR_W-1:0]    i_mni_fill_adr,
   input  logic [l2c_pkg::DATA_W-1:0]   i_mni_data
);
   import l2c_pkg::*;

   logic [N_PORTS-1:0] lk_req;
   logic [N_PORTS-1:0] lk_grant;
   logic [PORT_W-1:0]  lk_sel;
   logic [N_PORTS-1:0] miss_req;
   logic [N_PORTS-1:0] miss_done;
   logic [ADR_W-1:0]   il1_lk_adr;
   logic [ADR_W-1:0]   dl1_lk_adr;
   logic               il1_lk_wen;
   logic               dl1_lk_wen;
   logic [BE_W-1:0]    il1_lk_ben;
   logic [BE_W-1:0]    dl1_lk_ben;
   logic [DATA_W-1:0]  il1_lk_wdata;
   logic [DATA_W-1:0]  dl1_lk_wdata;
   logic               lk_hit;
   logic [DATA_W-1:0]  lk_rdata;
   logic [DATA_W-1:0]  install_data;

   // ==============================
   // Port engines
   // ==============================
   l2c_l1_port #(.CAN_WRITE(1'b0)) il1_port (
      .clk_mc(clk_mc), .i_reset(i_reset),
      .i_l1_adr(i_il1_adr), .i_l1_wen(), .i_l1_ben(), .i_l1_wdata(),
      .i_l1_valid(i_il1_valid), .o_l1_rdata_valid(o_il1_rdata_valid),
      .o_l1_rdata(o_il1_rdata), .o_l1_stall(o_il1_stall),
      .o_lookup_req(lk_req[PORT_IL1]), .o_lookup_adr(il1_lk_adr),
      .o_lookup_wen(il1_lk_wen), .o_lookup_ben(il1_lk_ben), .o_lookup_wdata(il1_lk_wdata),
      .i_grant(lk_grant[PORT_IL1]), .i_lookup_hit(lk_hit), .i_lookup_rdata(lk_rdata),
      .o_miss_req(miss_req[PORT_IL1]), .i_miss_done(miss_done[PORT_IL1]),
      .i_fill_data(i_mni_data)
   );

   l2c_l1_port #(.CAN_WRITE(1'b1)) dl1_port (
      .clk_mc(clk_mc), .i_reset(i_reset),
      .i_l1_adr(i_dl1_adr), .i_l1_wen(i_dl1_wen), .i_l1_ben(i_dl1_ben),
      .i_l1_wdata(i_dl1_wdata), .i_l1_valid(i_dl1_valid),
      .o_l1_rdata_valid(o_dl1_rdata_valid), .o_l1_rdata(o_dl1_rdata),
      .o_l1_stall(o_dl1_stall),
      .o_lookup_req(lk_req[PORT_DL1]), .o_lookup_adr(dl1_lk_adr),
      .o_lookup_wen(dl1_lk_wen), .o_lookup_ben(dl1_lk_ben), .o_lookup_wdata(dl1_lk_wdata),
      .i_grant(lk_grant[PORT_DL1]), .i_lookup_hit(lk_hit), .i_lookup_rdata(lk_rdata),
      .o_miss_req(miss_req[PORT_DL1]), .i_miss_done(miss_done[PORT_DL1]),
      .i_fill_data(i_mni_data)
   );

   // Fill cycles own the store
   l2c_arbiter u_arbiter (
      .clk_mc(clk_mc), .i_reset(i_reset),
      .i_req(lk_req), .i_fill_busy(i_mni_fill_valid),
      .o_grant(lk_grant), .o_sel(lk_sel)
   );

   l2c_store u_store (
      .clk_mc(clk_mc), .i_reset(i_reset),
      .i_lookup_valid(|lk_grant),
      .i_lookup_adr((lk_sel == PORT_DL1) ? dl1_lk_adr : il1_lk_adr),
      .i_lookup_wen((lk_sel == PORT_DL1) ? dl1_lk_wen : il1_lk_wen),
      .i_lookup_ben((lk_sel == PORT_DL1) ? dl1_lk_ben : il1_lk_ben),
      .i_lookup_wdata((lk_sel == PORT_DL1) ? dl1_lk_wdata : il1_lk_wdata),
      .o_lookup_hit(lk_hit), .o_lookup_rdata(lk_rdata),
      .i_fill_valid(i_mni_fill_valid), .i_fill_adr(i_mni_fill_adr),
      .i_fill_data(install_data)
   );

   // ==============================
   // Miss channel
   // ==============================
   l2c_miss u_miss (
      .clk_mc(clk_mc), .i_reset(i_reset),
      .i_miss_req(miss_req), .i_il1_adr(il1_lk_adr),
      .i_dl1_adr(dl1_lk_adr), .i_dl1_wen(dl1_lk_wen),
      .i_dl1_ben(dl1_lk_ben), .i_dl1_wdata(dl1_lk_wdata),
      .o_miss_done(miss_done), .o_fill_data(install_data),
      .o_mni_miss_valid(o_mni_miss_valid), .o_mni_miss_adr(o_mni_miss_adr),
      .o_mni_miss_wen(o_mni_miss_wen), .o_mni_miss_ben(o_mni_miss_ben),
      .o_mni_miss_wdata(o_mni_miss_wdata), .i_mni_miss_stall(i_mni_miss_stall),
      .i_mni_fill_valid(i_mni_fill_valid), .i_mni_fill_adr(i_mni_fill_adr),
      .i_mni_data(i_mni_data)
   );

endmodule

`default_nettype wire

// File: src.f
hw/l2c_pkg.sv
hw/l2c_l1_port.sv
hw/l2c_arbiter.sv
hw/l2c_store.sv
hw/l2c_miss.sv
hw/l2c_top.sv
verification/l2c_clkgen.sv
verification/l2c_checker.sv
verification/l2c_tb.sv

// File: verification/l2c_checker.sv
// ==============================
// L2 cache handshake assertions
// Bound to the top level
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_checker (
   input  logic                         clk_mc,
   input  logic                         i_reset,
   input  logic                         i_il1_rdata_valid,
   input  logic                         i_il1_stall,
   input  logic                         i_dl1_rdata_valid,
   input  logic                         i_dl1_stall,
   input  logic                         i_miss_valid,
   input  logic [l2c_pkg::ADR_W-1:0]    i_miss_adr,
   input  logic                         i_miss_wen,
   input  logic [l2c_pkg::BE_W-1:0]     i_miss_ben,
   input  logic [l2c_pkg::DATA_W-1:0]   i_miss_wdata,
   input  logic                         i_miss_stall,
   input  logic                         i_fill_valid
);
   import l2c_pkg::*;

   int   fail_cnt = 0;
   logic rd_pend_q;

   // Read miss sent, fill not back yet
   always_ff @(posedge clk_mc) begin
      if (i_reset) begin
         rd_pend_q <= 1'b0;
      end else if (i_miss_valid && !i_miss_stall && !i_miss_wen) begin
         rd_pend_q <= 1'b1;
      end else if (i_fill_valid) begin
         rd_pend_q <= 1'b0;
      end
   end

   // ==============================
   // Miss channel
   // ==============================
   payload_stable: assert property (@(posedge clk_mc) disable iff (i_reset)
      i_miss_valid && i_miss_stall |=> i_miss_valid && $stable(i_miss_adr) &&
      $stable(i_miss_wen) && $stable(i_miss_ben) && $stable(i_miss_wdata))
   else begin
      fail_cnt++;
      $error("miss payload changed while stalled");
   end

   single_read_miss: assert property (@(posedge clk_mc) disable iff (i_reset)
      rd_pend_q |-> !i_miss_valid)
   else begin
      fail_cnt++;
      $error("new miss request while a read miss is outstanding");
   end

   // ==============================
   // L1 side
   // ==============================
   il1_valid_in_stall: assert property (@(posedge clk_mc) disable iff (i_reset)
      i_il1_rdata_valid |-> i_il1_stall)
   else begin
      fail_cnt++;
      $error("instruction L1 data valid without stall");
   end

   dl1_valid_in_stall: assert property (@(posedge clk_mc) disable iff (i_reset)
      i_dl1_rdata_valid |-> i_dl1_stall)
   else begin
      fail_cnt++;
      $error("data L1 data valid without stall");
   end

   quiet_after_reset: assert property (@(posedge clk_mc)
      i_reset |=> !(i_il1_rdata_valid || i_il1_stall || i_dl1_rdata_valid ||
                    i_dl1_stall || i_miss_valid))
   else begin
      fail_cnt++;
      $error("control output high after reset");
   end

endmodule

`default_nettype wire

// File: verification/l2c_clkgen.sv
// ==============================
// Testbench clock and reset
// 8 ns clock, reset held for two cycles
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_clkgen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 2
) (
   output logic o_clk,
   output logic o_reset
);

   initial begin
      o_clk = 1'b0;
      forever begin
         #(PERIOD_NS / 2) o_clk = ~o_clk;
      end
   end

   // Reset drops on a rising edge
   initial begin
      o_reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_reset <= 1'b0;
   end

endmodule

`default_nettype wire

// File: verification/l2c_tb.sv
// ==============================
// L2 cache testbench
// Directed and random L1 traffic against a network memory model
// ==============================

`timescale 1ns/1ps
`default_nettype none

module l2c_tb;
   import l2c_pkg::*;

   localparam int          MAX_CYCLES = 6000;
   localparam logic [31:0] SEED       = 32'd31;
   localparam int          WA_W       = ADR_W - OFS_W;
   localparam logic [31:0] ADR_A      = 32'h0000_0040;
   localparam logic [31:0] ADR_B      = 32'h0000_0080;
   // Same index, different tag
   localparam logic [31:0] ADR_X      = 32'h3000_0010;
   localparam logic [31:0] ADR_Y      = 32'h3000_0110;
   localparam logic [31:0] IL1_BASE   = 32'h1000_0000;
   localparam logic [31:0] DL1_BASE   = 32'h2000_0000;

   logic              clk_mc;
   logic              i_reset;
   logic [ADR_W-1:0]  i_il1_adr;
   logic              i_il1_valid;
   logic              o_il1_rdata_valid;
   logic [DATA_W-1:0] o_il1_rdata;
   logic              o_il1_stall;
   logic [ADR_W-1:0]  i_dl1_adr;
   logic              i_dl1_wen;
   logic [BE_W-1:0]   i_dl1_ben;
   logic [DATA_W-1:0] i_dl1_wdata;
   logic              i_dl1_valid;
   logic              o_dl1_rdata_valid;
   logic [DATA_W-1:0] o_dl1_rdata;
   logic              o_dl1_stall;
   logic              o_mni_miss_valid;
   logic [ADR_W-1:0]  o_mni_miss_adr;
   logic              o_mni_miss_wen;
   logic [BE_W-1:0]   o_mni_miss_ben;
   logic [DATA_W-1:0] o_mni_miss_wdata;
   logic              i_mni_miss_stall;
   logic              i_mni_fill_valid;
   logic [ADR_W-1:0]  i_mni_fill_adr;
   logic [DATA_W-1:0] i_mni_data;

   // Network memory, words not written yet come from init_word
   logic [DATA_W-1:0] net_mem [logic [WA_W-1:0]];
   logic [31:0]       rng_state;
   int                miss_cnt;
   logic [ADR_W-1:0]  last_adr;
   logic              last_wen;
   logic [BE_W-1:0]   last_ben;
   logic [DATA_W-1:0] last_wdata;
   int                value_errs;
   int                other_errs;
   int                cycle_cnt;

   l2c_clkgen clkgen (.o_clk(clk_mc), .o_reset(i_reset));

   l2c_top dut (.*);

   bind l2c_top l2c_checker u_checker (
      .clk_mc(clk_mc), .i_reset(i_reset),
      .i_il1_rdata_valid(o_il1_rdata_valid), .i_il1_stall(o_il1_stall),
      .i_dl1_rdata_valid(o_dl1_rdata_valid), .i_dl1_stall(o_dl1_stall),
      .i_miss_valid(o_mni_miss_valid), .i_miss_adr(o_mni_miss_adr),
      .i_miss_wen(o_mni_miss_wen), .i_miss_ben(o_mni_miss_ben),
      .i_miss_wdata(o_mni_miss_wdata), .i_miss_stall(i_mni_miss_stall),
      .i_fill_valid(i_mni_fill_valid)
   );

   // ==============================
   // Random numbers and memory model
   // ==============================
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] rand_word();
      rng_state = lcg_next(rng_state);
      return rng_state ^ (rng_state >> 15);
   endfunction

   function automatic logic [DATA_W-1:0] init_word(input logic [WA_W-1:0] wa);
      return lcg_next(lcg_next(32'(wa) ^ SEED));
   endfunction

   function automatic logic [DATA_W-1:0] mem_read(input logic [WA_W-1:0] wa);
      if (net_mem.exists(wa)) begin
         return net_mem[wa];
      end
      return init_word(wa);
   endfunction

   function automatic void mem_write_bytes(input logic [WA_W-1:0] wa,
                                           input logic [BE_W-1:0] ben,
                                           input logic [DATA_W-1:0] wdata);
      logic [DATA_W-1:0] w;
      w = mem_read(wa);
      for (int b = 0; b < BE_W; b++) begin
         if (ben[b]) begin
            w[8*b +: 8] = wdata[8*b +: 8];
         end
      end
      net_mem[wa] = w;
   endfunction

   // ==============================
   // Checks and reporting
   // ==============================
   function automatic void compare_word(input string name, input logic [31:0] exp,
                                        input logic [31:0] got);
      if (exp !== got) begin
         $display("ERR %s exp=%h got=%h", name, exp, got);
         value_errs++;
      end
   endfunction

   function automatic void confirm(input logic cond, input string what);
      if (cond !== 1'b1) begin
         $display("Check failed: %s", what);
         other_errs++;
      end
   endfunction

   task automatic report_counts();
      $display("Error counts: value=%0d other=%0d assertion=%0d",
               value_errs, other_errs, dut.u_checker.fail_cnt);
   endtask

   // ==============================
   // L1 requests
   // ==============================
   task automatic il1_read(input logic [ADR_W-1:0] adr);
      @(posedge clk_mc);
      i_il1_valid <= 1'b1;
      i_il1_adr   <= adr;
      do @(negedge clk_mc); while (o_il1_stall);
      @(posedge clk_mc);
      i_il1_valid <= 1'b0;
      do @(negedge clk_mc); while (!o_il1_rdata_valid);
      compare_word("o_il1_rdata", mem_read(adr[ADR_W-1:OFS_W]), o_il1_rdata);
   endtask

   task automatic dl1_access(input logic wen, input logic [ADR_W-1:0] adr,
                             input logic [BE_W-1:0] ben, input logic [DATA_W-1:0] wdata);
      @(posedge clk_mc);
      i_dl1_valid <= 1'b1;
      i_dl1_wen   <= wen;
      i_dl1_adr   <= adr;
      i_dl1_ben   <= ben;
      i_dl1_wdata <= wdata;
      do @(negedge clk_mc); while (o_dl1_stall);
      @(posedge clk_mc);
      i_dl1_valid <= 1'b0;
      do @(negedge clk_mc); while (!o_dl1_rdata_valid);
      if (wen) begin
         // Write ends one cycle after its transfer
         confirm(last_wen, "data L1 write did not go out as a write");
         compare_word("o_mni_miss_adr", adr, last_adr);
         compare_word("o_mni_miss_ben", ben, last_ben);
         compare_word("o_mni_miss_wdata", wdata, last_wdata);
      end else begin
         compare_word("o_dl1_rdata", mem_read(adr[ADR_W-1:OFS_W]), o_dl1_rdata);
      end
   endtask

   task automatic dl1_random_access();
      logic [31:0] r;
      logic [31:0] wdata;
      r     = rand_word();
      wdata = rand_word();
      dl1_access(r[21], DL1_BASE | ((r % 32'd128) << 2), r[27:24], wdata);
   endtask

   // ==============================
   // Network side
   // ==============================
   initial begin : network_model
      logic              fill_pend;
      int                fill_wait;
      logic [ADR_W-1:0]  fill_adr;
      fill_pend = 1'b0;
      fill_wait = 0;
      fill_adr  = '0;
      forever begin
         @(negedge clk_mc);
         if (!i_reset && o_mni_miss_valid === 1'b1 && !i_mni_miss_stall) begin
            miss_cnt++;
            last_adr   = o_mni_miss_adr;
            last_wen   = o_mni_miss_wen;
            last_ben   = o_mni_miss_ben;
            last_wdata = o_mni_miss_wdata;
            if (o_mni_miss_wen) begin
               mem_write_bytes(o_mni_miss_adr[ADR_W-1:OFS_W], o_mni_miss_ben,
                               o_mni_miss_wdata);
            end else begin
               fill_pend = 1'b1;
               fill_wait = rand_word() % 4;
               fill_adr  = o_mni_miss_adr;
            end
         end
         @(posedge clk_mc);
         i_mni_miss_stall <= (rand_word() % 3) == 0;
         i_mni_fill_valid <= 1'b0;
         if (fill_pend && fill_wait == 0) begin
            i_mni_fill_valid <= 1'b1;
            i_mni_fill_adr   <= fill_adr;
            i_mni_data       <= mem_read(fill_adr[ADR_W-1:OFS_W]);
            fill_pend = 1'b0;
         end else if (fill_pend) begin
            fill_wait--;
         end
      end
   end

   always @(posedge clk_mc) begin
      cycle_cnt++;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
         report_counts();
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // ==============================
   // Test sequence
   // ==============================
   initial begin : main_flow
      int misses_before;
      i_il1_adr        = '0;
      i_il1_valid      = 1'b0;
      i_dl1_adr        = '0;
      i_dl1_wen        = 1'b0;
      i_dl1_ben        = '0;
      i_dl1_wdata      = '0;
      i_dl1_valid      = 1'b0;
      i_mni_miss_stall = 1'b0;
      i_mni_fill_valid = 1'b0;
      i_mni_fill_adr   = '0;
      i_mni_data       = '0;
      rng_state        = SEED;
      miss_cnt         = 0;
      value_errs       = 0;
      other_errs       = 0;
      cycle_cnt        = 0;
      do @(negedge clk_mc); while (i_reset);

      // Read miss, then hit on the same word
      misses_before = miss_cnt;
      il1_read(ADR_A);
      confirm(miss_cnt == misses_before + 1, "first read of a word did not miss");
      compare_word("o_mni_miss_adr", ADR_A, last_adr);
      confirm(!last_wen, "read miss went out as a write");
      il1_read(ADR_A);
      confirm(miss_cnt == misses_before + 1, "second read of a word missed again");

      // Write hit merges, write miss does not allocate
      dl1_access(1'b1, ADR_A, 4'b0101, 32'hA5C3_0F96);
      dl1_access(1'b0, ADR_A, '0, '0);
      il1_read(ADR_A);
      dl1_access(1'b1, ADR_B, 4'b1000, 32'h7E00_0000);
      misses_before = miss_cnt;
      dl1_access(1'b0, ADR_B, '0, '0);
      confirm(miss_cnt == misses_before + 1, "read after a write miss did not miss");

      // Index conflict
      for (int n = 0; n < 6; n++) begin
         misses_before = miss_cnt;
         dl1_access(1'b0, n[0] ? ADR_Y : ADR_X, '0, '0);
         confirm(miss_cnt == misses_before + 1, "conflicting address did not miss");
      end

      // Both L1s at once under random miss stall
      fork
         for (int n = 0; n < 80; n++) begin
            il1_read(IL1_BASE | ((rand_word() % 32'd128) << 2));
         end
         for (int n = 0; n < 100; n++) begin
            dl1_random_access();
         end
      join

      repeat (4) @(posedge clk_mc);
      report_counts();
      if (value_errs == 0 && other_errs == 0 && dut.u_checker.fail_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
